// File: Bender.yml
package:
  name: dtim_subsys

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/dtimPkg.sv
      - hdl/loadAlign.sv
      - hdl/simpleRam.sv
      - hdl/dtim.sv
      - hdl/memReqQueue.sv
      - hdl/lsuIssue.sv
      - hdl/dtimSubsys.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/dtimSubsys_tb.sv

// File: dtimSubsys.f
+incdir+include
hdl/dtimPkg.sv
hdl/loadAlign.sv
hdl/simpleRam.sv
hdl/dtim.sv
hdl/memReqQueue.sv
hdl/lsuIssue.sv
hdl/dtimSubsys.sv
tests/dtimSubsys_tb.sv

// File: hdl/dtim.sv
////////////////////////////////////////////////////////////////////////////
// DTIM access FSM with write suppression and response hold
////////////////////////////////////////////////////////////////////////////

module dtim (
  input  logic             clk,
  input  logic             arstN,
  input  logic             headValid,
  input  dtimPkg::memOp    headOp,
  input  dtimPkg::accSize  headSize,
  input  logic             headUnsigned,
  input  dtimPkg::xlenAdr  headAdr,
  input  dtimPkg::byteMask headMask,
  input  dtimPkg::xlenWord headWdata,
  input  logic             headTrap,
  input  logic             headMisaligned,
  input  logic             rspReady,
  output logic             pop,
  output logic             rspValid,
  output dtimPkg::memOp    rspOp,
  output logic             rspFault,
  output dtimPkg::xlenWord rspData
);

  dtimPkg::dtimState state;
  dtimPkg::xlenWord  ramRd;
  dtimPkg::accSize   sizeQ;
  logic              ramInRange;
  logic              ramWe;
  logic              unsignedQ;
  logic [1:0]        byteOffQ;
  logic              zeroData;

  // A new request is only taken with no response outstanding
  assign pop      = (state == dtimPkg::stIdle) && headValid;
  assign rspValid = (state != dtimPkg::stIdle);

  // A trap, a misaligned address or a miss on the window kills the write
  assign ramWe = (headOp == dtimPkg::opStore) && !headTrap && !headMisaligned && ramInRange;

  simpleRam ram (
    .clk, .en(pop), .we(ramWe), .adr(headAdr), .mask(headMask),
    .wd(headWdata), .rd(ramRd), .inRange(ramInRange));

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= dtimPkg::stIdle;
    end else begin
      case (state)
        dtimPkg::stIdle:   if (pop) state <= dtimPkg::stAccess;
        dtimPkg::stAccess: state <= rspReady ? dtimPkg::stIdle : dtimPkg::stHold;
        dtimPkg::stHold:   if (rspReady) state <= dtimPkg::stIdle;
        default:           state <= dtimPkg::stIdle;
      endcase
    end
  end

  // Response fields captured next to the RAM read
  always_ff @(posedge clk) begin
    if (pop) begin
      rspOp     <= headOp;
      sizeQ     <= headSize;
      unsignedQ <= headUnsigned;
      byteOffQ  <= headAdr[1:0];
      rspFault  <= headMisaligned | ~ramInRange;
    end
  end

  // Stores and faulting loads give no data
  assign zeroData = rspFault | (rspOp == dtimPkg::opStore);

  loadAlign align (
    .rdWord(ramRd), .size(sizeQ), .byteOff(byteOffQ), .isUnsigned(unsignedQ),
    .fault(zeroData), .data(rspData));

endmodule

// File: hdl/dtimPkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared types of the DTIM subsystem
////////////////////////////////////////////////////////////////////////////

`include "dtim_consts.svh"

package dtimPkg;

  // One data word as moved between the core and the RAM
  typedef logic [`XLEN-1:0] xlenWord;

  // Byte address, same width as the data path
  typedef logic [`XLEN-1:0] xlenAdr;

  // One write enable per byte lane
  typedef logic [`XLEN/8-1:0] byteMask;

  // Access size code, 0 byte, 1 halfword, 2 word
  typedef logic [1:0] accSize;

  // Kind of memory operation
  typedef enum logic {
    opLoad,
    opStore
  } memOp;

  // DTIM access FSM
  typedef enum logic [1:0] {
    stIdle,
    stAccess,
    stHold
  } dtimState;

endpackage

// File: hdl/dtimSubsys.sv
////////////////////////////////////////////////////////////////////////////
// DTIM subsystem top with issue stage, request queue and DTIM
////////////////////////////////////////////////////////////////////////////

module dtimSubsys (
  input  logic             clk,
  input  logic             arstN,
  input  logic             reqValid,
  input  dtimPkg::memOp    reqOp,
  input  dtimPkg::accSize  reqSize,
  input  logic             reqUnsigned,
  input  dtimPkg::xlenAdr  reqAdr,
  input  dtimPkg::xlenWord reqWdata,
  input  logic             reqTrap,
  input  logic             rspReady,
  output logic             reqReady,
  output logic             rspValid,
  output dtimPkg::memOp    rspOp,
  output dtimPkg::xlenWord rspData,
  output logic             rspFault
);

  // Issue stage to queue
  logic             pushValid, pushUnsigned, pushTrap, pushMisaligned;
  dtimPkg::memOp    pushOp;
  dtimPkg::accSize  pushSize;
  dtimPkg::xlenAdr  pushAdr;
  dtimPkg::byteMask pushMask;
  dtimPkg::xlenWord pushWdata;
  logic             creditReturn;

  // Queue head to DTIM
  logic             headValid, headUnsigned, headTrap, headMisaligned, pop;
  dtimPkg::memOp    headOp;
  dtimPkg::accSize  headSize;
  dtimPkg::xlenAdr  headAdr;
  dtimPkg::byteMask headMask;
  dtimPkg::xlenWord headWdata;

  lsuIssue issue (
    .clk, .arstN, .reqValid, .reqUnsigned, .reqTrap, .reqOp, .reqSize, .reqAdr,
    .reqWdata, .creditReturn, .reqReady, .pushValid, .pushUnsigned, .pushTrap,
    .pushMisaligned, .pushOp, .pushSize, .pushAdr, .pushMask, .pushWdata);

  memReqQueue queue (
    .clk, .arstN, .pushValid, .pushOp, .pushSize, .pushUnsigned, .pushAdr, .pushMask,
    .pushWdata, .pushTrap, .pushMisaligned, .pop, .headValid, .headOp, .headSize,
    .headUnsigned, .headAdr, .headMask, .headWdata, .headTrap, .headMisaligned,
    .creditReturn);

  dtim mem (
    .clk, .arstN, .headValid, .headOp, .headSize, .headUnsigned, .headAdr, .headMask,
    .headWdata, .headTrap, .headMisaligned, .rspReady, .pop, .rspValid, .rspOp,
    .rspFault, .rspData);

endmodule

// File: hdl/loadAlign.sv
////////////////////////////////////////////////////////////////////////////
// Load lane select with zero or sign extension
////////////////////////////////////////////////////////////////////////////

`include "dtim_consts.svh"

module loadAlign (
  input  dtimPkg::xlenWord rdWord,
  input  dtimPkg::accSize  size,
  input  logic [1:0]       byteOff,
  input  logic             isUnsigned,
  input  logic             fault,
  output dtimPkg::xlenWord data
);

  dtimPkg::xlenWord shifted;
  logic             byteSign;
  logic             halfSign;

  // Bring the addressed lane down to bit 0
  assign shifted = rdWord >> {byteOff, 3'b000};

  // Sign bits only matter for signed loads
  assign byteSign = ~isUnsigned & shifted[7];
  assign halfSign = ~isUnsigned & shifted[15];

  always_comb begin
    case (size)
      2'd0:    data = {{(`XLEN-8){byteSign}}, shifted[7:0]};
      2'd1:    data = {{(`XLEN-16){halfSign}}, shifted[15:0]};
      // A word is aligned whenever it is not a fault
      default: data = rdWord;
    endcase
    if (fault) begin
      data = '0;
    end
  end

endmodule

// File: hdl/lsuIssue.sv
////////////////////////////////////////////////////////////////////////////
// Issue stage with alignment check, byte mask, lane data and credits
////////////////////////////////////////////////////////////////////////////

`include "dtim_consts.svh"

module lsuIssue (
  input  logic             clk,
  input  logic             arstN,
  input  logic             reqValid,
  input  logic             reqUnsigned,
  input  logic             reqTrap,
  input  dtimPkg::memOp    reqOp,
  input  dtimPkg::accSize  reqSize,
  input  dtimPkg::xlenAdr  reqAdr,
  input  dtimPkg::xlenWord reqWdata,
  input  logic             creditReturn,
  output logic             reqReady,
  output logic             pushValid,
  output logic             pushUnsigned,
  output logic             pushTrap,
  output logic             pushMisaligned,
  output dtimPkg::memOp    pushOp,
  output dtimPkg::accSize  pushSize,
  output dtimPkg::xlenAdr  pushAdr,
  output dtimPkg::byteMask pushMask,
  output dtimPkg::xlenWord pushWdata
);

  localparam int CW = $clog2(`QUEUE_DEPTH + 1);

  logic [CW-1:0]    creditCnt;
  logic             accept;
  logic             misaligned;
  dtimPkg::byteMask laneMask;
  dtimPkg::xlenWord laneData;

  // The output register drains every cycle since the queue never refuses a push,
  // so only the credit count can hold off a new operation
  assign reqReady = (creditCnt != '0);
  assign accept   = reqValid && reqReady;

  // Alignment, byte mask and lane replication depend on size and low address bits
  always_comb begin
    case (reqSize)
      2'd0: begin
        misaligned = 1'b0;
        laneMask   = dtimPkg::byteMask'(1) << reqAdr[1:0];
        laneData   = {(`XLEN/8){reqWdata[7:0]}};
      end
      2'd1: begin
        misaligned = reqAdr[0];
        laneMask   = dtimPkg::byteMask'(3) << {reqAdr[1], 1'b0};
        laneData   = {(`XLEN/16){reqWdata[15:0]}};
      end
      default: begin
        // Size code 3 is treated as a full word
        misaligned = (reqAdr[1:0] != 2'b00);
        laneMask   = '1;
        laneData   = reqWdata;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pushValid <= 1'b0;
      creditCnt <= CW'(`QUEUE_DEPTH);
    end else begin
      pushValid <= accept;
      // One credit spent per accept, one regained per pop in the queue
      case ({accept, creditReturn})
        2'b10:   creditCnt <= creditCnt - 1'b1;
        2'b01:   creditCnt <= creditCnt + 1'b1;
        default: creditCnt <= creditCnt;
      endcase
    end
  end

  // Request payload, only loaded on an accept
  always_ff @(posedge clk) begin
    if (accept) begin
      pushOp         <= reqOp;
      pushSize       <= reqSize;
      pushUnsigned   <= reqUnsigned;
      pushTrap       <= reqTrap;
      pushAdr        <= reqAdr;
      pushMask       <= laneMask;
      pushWdata      <= laneData;
      pushMisaligned <= misaligned;
    end
  end

  // Returned credits never push the count above the queue size
  creditBound : assert property (@(posedge clk) disable iff (!arstN)
    creditCnt <= CW'(`QUEUE_DEPTH));

endmodule

// File: hdl/memReqQueue.sv
////////////////////////////////////////////////////////////////////////////
// Circular request FIFO that hands one credit back per pop
////////////////////////////////////////////////////////////////////////////

`include "dtim_consts.svh"

module memReqQueue #(
  parameter int DEPTH = `QUEUE_DEPTH
) (
  input  logic             clk,
  input  logic             arstN,
  input  logic             pushValid,
  input  dtimPkg::memOp    pushOp,
  input  dtimPkg::accSize  pushSize,
  input  logic             pushUnsigned,
  input  dtimPkg::xlenAdr  pushAdr,
  input  dtimPkg::byteMask pushMask,
  input  dtimPkg::xlenWord pushWdata,
  input  logic             pushTrap,
  input  logic             pushMisaligned,
  input  logic             pop,
  output logic             headValid,
  output dtimPkg::memOp    headOp,
  output dtimPkg::accSize  headSize,
  output logic             headUnsigned,
  output dtimPkg::xlenAdr  headAdr,
  output dtimPkg::byteMask headMask,
  output dtimPkg::xlenWord headWdata,
  output logic             headTrap,
  output logic             headMisaligned,
  output logic             creditReturn
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  dtimPkg::memOp    opMem   [DEPTH];
  dtimPkg::accSize  sizeMem [DEPTH];
  dtimPkg::xlenAdr  adrMem  [DEPTH];
  dtimPkg::byteMask maskMem [DEPTH];
  dtimPkg::xlenWord dataMem [DEPTH];
  logic [2:0]       flagMem [DEPTH];
  logic [PW-1:0]    wrPtr;
  logic [PW-1:0]    rdPtr;
  logic [CW-1:0]    count;

  // Pointer step that wraps also for a depth that is not a power of two
  function automatic logic [PW-1:0] nextPtr(input logic [PW-1:0] p);
    return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // Entry storage, written at the tail
  always_ff @(posedge clk) begin
    if (pushValid) begin
      opMem[wrPtr]   <= pushOp;
      sizeMem[wrPtr] <= pushSize;
      adrMem[wrPtr]  <= pushAdr;
      maskMem[wrPtr] <= pushMask;
      dataMem[wrPtr] <= pushWdata;
      flagMem[wrPtr] <= {pushUnsigned, pushTrap, pushMisaligned};
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wrPtr        <= '0;
      rdPtr        <= '0;
      count        <= '0;
      creditReturn <= 1'b0;
    end else begin
      if (pushValid) wrPtr <= nextPtr(wrPtr);
      if (pop) rdPtr <= nextPtr(rdPtr);
      case ({pushValid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Credit goes back one cycle after the entry leaves
      creditReturn <= pop;
    end
  end

  // Head entry shown straight from the storage
  assign headValid      = (count != '0);
  assign headOp         = opMem[rdPtr];
  assign headSize       = sizeMem[rdPtr];
  assign headAdr        = adrMem[rdPtr];
  assign headMask       = maskMem[rdPtr];
  assign headWdata      = dataMem[rdPtr];
  assign {headUnsigned, headTrap, headMisaligned} = flagMem[rdPtr];

  // Issue credits must keep pushes away from a full queue
  noPushFull : assert property (@(posedge clk) disable iff (!arstN)
    pushValid |-> (count != CW'(DEPTH)));
  // The DTIM only pops an entry that is there
  noPopEmpty : assert property (@(posedge clk) disable iff (!arstN) pop |-> headValid);

endmodule

// File: hdl/simpleRam.sv
////////////////////////////////////////////////////////////////////////////
// Byte-masked synchronous RAM behind an address window
////////////////////////////////////////////////////////////////////////////

`include "dtim_consts.svh"

module simpleRam (
  input  logic             clk,
  input  logic             en,
  input  logic             we,
  input  dtimPkg::xlenAdr  adr,
  input  dtimPkg::byteMask mask,
  input  dtimPkg::xlenWord wd,
  output dtimPkg::xlenWord rd,
  output logic             inRange
);

  localparam int BYTES = `XLEN / 8;
  localparam int OFFW  = $clog2(BYTES);
  localparam int WORDS = (`RAM_RANGE + 1) / BYTES;
  localparam int IDXW  = $clog2(WORDS);

  dtimPkg::xlenWord mem [WORDS];
  dtimPkg::xlenAdr  offset;
  logic [IDXW-1:0]  idx;

  // Window decode relative to the RAM base
  assign offset  = adr - dtimPkg::xlenAdr'(`RAM_BASE);
  assign inRange = (adr >= dtimPkg::xlenAdr'(`RAM_BASE)) &&
                   (offset <= dtimPkg::xlenAdr'(`RAM_RANGE));

  // Word index sits just above the byte offset bits
  assign idx = offset[OFFW +: IDXW];

  always_ff @(posedge clk) begin
    if (en) begin
      if (we && inRange) begin
        for (int i = 0; i < BYTES; i++) begin
          if (mask[i]) mem[idx][8*i +: 8] <= wd[8*i +: 8];
        end
      end
      // Read returns the old word on a write, and zero outside the window
      rd <= inRange ? mem[idx] : '0;
    end
  end

endmodule

// File: include/dtim_consts.svh
////////////////////////////////////////////////////////////////////////////
// Width, RAM window and request queue depth constants for the DTIM
////////////////////////////////////////////////////////////////////////////

`ifndef DTIM_CONSTS_SVH
`define DTIM_CONSTS_SVH

// Data and address width of the load/store path
`define XLEN 32

////////////////////////////////////////////////////////////////////////////
// RAM window
////////////////////////////////////////////////////////////////////////////

// First byte address that maps onto the DTIM
`define RAM_BASE 32'h8000_0000

// Highest byte offset inside the window, 4 KiB in total
`define RAM_RANGE 32'h0000_0FFF

////////////////////////////////////////////////////////////////////////////
// Request queue
////////////////////////////////////////////////////////////////////////////

// Queue entries, and so also the credit count after reset
`define QUEUE_DEPTH 4

`endif

// File: tests/dtimSubsys_tb.sv
////////////////////////////////////////////////////////////////////////////
// DTIM subsystem testbench with byte-array reference model and checker
////////////////////////////////////////////////////////////////////////////

`include "dtim_consts.svh"

module dtimSubsys_tb;

  localparam int FILL_WORDS  = 1024;
  localparam int LOAD_CHECKS = 32;
  localparam int EXT_WORDS   = 4;
  localparam int TRAP_OPS    = 4;
  localparam int FAULT_OPS   = 13;
  localparam int BP_OPS      = 8;
  localparam int RAND_OPS    = 400;
  localparam int TOTAL_OPS   = FILL_WORDS + LOAD_CHECKS + EXT_WORDS * 15 + TRAP_OPS * 2 +
                               FAULT_OPS + BP_OPS + RAND_OPS;
  localparam int CYCLE_LIMIT = 20 * TOTAL_OPS + 200;

  logic clk, arstN, reqValid, reqUnsigned, reqTrap, rspReady;
  logic reqReady, rspValid, rspFault;
  dtimPkg::memOp    reqOp, rspOp;
  dtimPkg::accSize  reqSize;
  dtimPkg::xlenAdr  reqAdr;
  dtimPkg::xlenWord reqWdata, rspData;

  // Reference image of the 4 KiB window, one entry per byte
  logic [7:0] model [0:4095];

  // Expected responses in acceptance order
  dtimPkg::memOp    expOp[$];
  dtimPkg::xlenWord expData[$];
  logic             expFault[$];

  int issuedCount, rspCount, valueErrs, otherErrs, cycleCount, readyMode;
  logic             stallSeen, holdValid, heldFault;
  dtimPkg::memOp    heldOp;
  dtimPkg::xlenWord heldData;

  dtimSubsys uut (
    .clk, .arstN, .reqValid, .reqOp, .reqSize, .reqUnsigned, .reqAdr, .reqWdata,
    .reqTrap, .rspReady, .reqReady, .rspValid, .rspOp, .rspData, .rspFault);

  always #5 clk = ~clk;

  // Initial memory contents, mixing every address bit into the word
  function automatic dtimPkg::xlenWord fillWord(input dtimPkg::xlenAdr adr);
    return (adr * 32'h9E37_79B1) ^ 32'hC3A5_5A3C;
  endfunction

  // Applies one operation to the byte image and returns the expected data
  function automatic dtimPkg::xlenWord refModel(
    input dtimPkg::memOp op, input dtimPkg::accSize size, input logic uns,
    input dtimPkg::xlenAdr adr, input dtimPkg::xlenWord wdata, input logic trap,
    output logic fault);
    dtimPkg::xlenAdr  off;
    dtimPkg::xlenWord val;
    int               nBytes;
    logic             inWin;
    off    = adr - `RAM_BASE;
    nBytes = 1 << size;
    inWin  = (adr >= `RAM_BASE) && (off <= `RAM_RANGE);
    fault  = ((adr & (nBytes - 1)) != 0) || !inWin;
    val    = '0;
    if (!fault) begin
      for (int i = 0; i < nBytes; i++) begin
        // A trapped store still answers but must leave the bytes alone
        if (op == dtimPkg::opStore && !trap) model[off + i] = wdata[8*i +: 8];
        val[8*i +: 8] = model[off + i];
      end
    end
    if (op == dtimPkg::opStore || fault) return '0;
    if (!uns && nBytes < 4 && val[8*nBytes-1]) val = val | (32'hFFFF_FFFF << (8 * nBytes));
    return val;
  endfunction

  task automatic reportValue(input string name, input logic [31:0] exp, input logic [31:0] act);
    valueErrs++;
    $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
  endtask

  // Drives one operation right after a rising edge and returns on the edge that accepts it
  task automatic sendOp(input dtimPkg::memOp op, input dtimPkg::accSize size, input logic uns,
                        input dtimPkg::xlenAdr adr, input dtimPkg::xlenWord wdata,
                        input logic trap);
    dtimPkg::xlenWord ed;
    logic             ef;
    reqValid    <= 1'b1;
    reqOp       <= op;
    reqSize     <= size;
    reqUnsigned <= uns;
    reqAdr      <= adr;
    reqWdata    <= wdata;
    reqTrap     <= trap;
    @(negedge clk);
    while (!reqReady) begin
      stallSeen = 1'b1;
      @(negedge clk);
    end
    @(posedge clk);
    ed = refModel(op, size, uns, adr, wdata, trap, ef);
    expOp.push_back(op);
    expData.push_back(ed);
    expFault.push_back(ef);
    issuedCount++;
  endtask

  // Mostly aligned in-window traffic with some misaligned, outside and trapped cases
  task automatic randomOp();
    dtimPkg::accSize size;
    dtimPkg::xlenAdr adr;
    int              r, off;
    r    = $urandom % 16;
    size = dtimPkg::accSize'($urandom % 3);
    off  = $urandom % 4096;
    if (r == 0) adr = `RAM_BASE + 32'h1000 + off;
    else if (r == 1) adr = `RAM_BASE + off;
    else adr = `RAM_BASE + (off & ~((1 << size) - 1));
    sendOp(dtimPkg::memOp'($urandom % 2), size, $urandom % 2, adr, $urandom,
           ($urandom % 16) == 0);
  endtask

  // Response back-pressure, 0 always ready, 1 half, 2 held low, 3 mostly ready
  always @(posedge clk) begin
    case (readyMode)
      0:       rspReady <= 1'b1;
      1:       rspReady <= $urandom % 2;
      2:       rspReady <= 1'b0;
      default: rspReady <= ($urandom % 4) != 0;
    endcase
  end

  // Response checker, sampled at the falling edge where all DUT outputs are settled
  always @(negedge clk) begin
    if (arstN) begin
      if (holdValid) begin
        if (!rspValid) begin
          otherErrs++;
          $display("Time %0t: rspValid dropped before the response was taken", $time);
        end
        if (rspData !== heldData) reportValue("rspData (held)", heldData, rspData);
        if (rspOp !== heldOp) reportValue("rspOp (held)", heldOp, rspOp);
        if (rspFault !== heldFault) reportValue("rspFault (held)", heldFault, rspFault);
      end
      holdValid = rspValid && !rspReady;
      heldData  = rspData;
      heldOp    = rspOp;
      heldFault = rspFault;
      if (rspValid && rspReady) begin
        rspCount++;
        if (expData.size() == 0) begin
          otherErrs++;
          $display("Time %0t: a response came with no operation outstanding", $time);
        end else begin
          if (rspOp !== expOp[0]) reportValue("rspOp", expOp[0], rspOp);
          if (rspData !== expData[0]) reportValue("rspData", expData[0], rspData);
          if (rspFault !== expFault[0]) reportValue("rspFault", expFault[0], rspFault);
          void'(expOp.pop_front());
          void'(expData.pop_front());
          void'(expFault.pop_front());
        end
      end
    end
  end

  // Guard against a hung handshake
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > CYCLE_LIMIT) begin
      $display("Run stopped after %0d cycles with %0d of %0d responses received",
               cycleCount, rspCount, issuedCount);
      $display("Testbench failed");
      $finish;
    end
  end

  initial begin
    dtimPkg::xlenAdr a;
    void'($urandom(36182));
    clk         = 1'b0;
    arstN       = 1'b0;
    reqValid    = 1'b0;
    reqOp       = dtimPkg::opLoad;
    reqSize     = '0;
    reqUnsigned = 1'b0;
    reqAdr      = '0;
    reqWdata    = '0;
    reqTrap     = 1'b0;
    rspReady    = 1'b0;
    readyMode   = 0;
    holdValid   = 1'b0;
    repeat (5) @(posedge clk);
    arstN <= 1'b1;
    @(posedge clk);

    ////////////////////////////////////////////////////////////////////////////
    // Fill the window with word stores, then read words back
    ////////////////////////////////////////////////////////////////////////////
    for (int w = 0; w < FILL_WORDS; w++) begin
      a = `RAM_BASE + 4 * w;
      sendOp(dtimPkg::opStore, 2'd2, 1'b0, a, fillWord(a), 1'b0);
    end
    for (int i = 0; i < LOAD_CHECKS; i++)
      sendOp(dtimPkg::opLoad, 2'd2, 1'b0, `RAM_BASE + 4 * ($urandom % FILL_WORDS), '0, 1'b0);

    // Byte and halfword loads at every offset, then sub-word stores read back as words
    for (int w = 0; w < EXT_WORDS; w++) begin
      a = `RAM_BASE + 4 * (w * 37 + 5);
      for (int u = 0; u < 2; u++) begin
        for (int o = 0; o < 4; o++) sendOp(dtimPkg::opLoad, 2'd0, u, a + o, '0, 1'b0);
        for (int o = 0; o < 4; o += 2) sendOp(dtimPkg::opLoad, 2'd1, u, a + o, '0, 1'b0);
      end
      sendOp(dtimPkg::opStore, 2'd0, 1'b0, a + (w % 4), $urandom, 1'b0);
      sendOp(dtimPkg::opStore, 2'd1, 1'b0, a + 2 * (w % 2), $urandom, 1'b0);
      sendOp(dtimPkg::opLoad, 2'd2, 1'b0, a, '0, 1'b0);
    end

    // Trapped stores answer without a fault and leave the word as it was
    for (int i = 0; i < TRAP_OPS; i++) begin
      a = `RAM_BASE + 4 * ($urandom % FILL_WORDS);
      sendOp(dtimPkg::opStore, 2'd2, 1'b0, a, $urandom, 1'b1);
      sendOp(dtimPkg::opLoad, 2'd2, 1'b0, a, '0, 1'b0);
    end

    // Misaligned and out-of-window accesses
    sendOp(dtimPkg::opLoad, 2'd1, 1'b0, `RAM_BASE + 32'h201, '0, 1'b0);
    sendOp(dtimPkg::opStore, 2'd1, 1'b0, `RAM_BASE + 32'h203, 32'h0000_BEEF, 1'b0);
    sendOp(dtimPkg::opLoad, 2'd2, 1'b0, `RAM_BASE + 32'h202, '0, 1'b0);
    sendOp(dtimPkg::opStore, 2'd2, 1'b0, `RAM_BASE + 32'h201, 32'hDEAD_BEEF, 1'b0);
    sendOp(dtimPkg::opLoad, 2'd2, 1'b0, `RAM_BASE + 32'h200, '0, 1'b0);
    sendOp(dtimPkg::opLoad, 2'd0, 1'b0, `RAM_BASE + 32'h1000, '0, 1'b0);
    sendOp(dtimPkg::opStore, 2'd2, 1'b0, `RAM_BASE + 32'h1000, 32'h1234_5678, 1'b0);
    sendOp(dtimPkg::opLoad, 2'd2, 1'b0, 32'h7FFF_FFFC, '0, 1'b0);
    sendOp(dtimPkg::opStore, 2'd2, 1'b0, 32'h7FFF_FFFC, 32'hCAFE_F00D, 1'b0);
    sendOp(dtimPkg::opLoad, 2'd2, 1'b0, 32'h0000_0010, '0, 1'b0);
    sendOp(dtimPkg::opStore, 2'd0, 1'b0, `RAM_BASE - 1, 32'h0000_00AA, 1'b0);
    sendOp(dtimPkg::opLoad, 2'd2, 1'b0, `RAM_BASE, '0, 1'b0);
    // Stores just below the base would land in the last word if the decode wrapped
    sendOp(dtimPkg::opLoad, 2'd2, 1'b0, `RAM_BASE + 32'hFFC, '0, 1'b0);

    ////////////////////////////////////////////////////////////////////////////
    // Back-pressure, then a long random mix
    ////////////////////////////////////////////////////////////////////////////
    stallSeen = 1'b0;
    readyMode <= 2;
    fork
      for (int i = 0; i < BP_OPS; i++) randomOp();
      begin
        repeat (30) @(posedge clk);
        readyMode <= 1;
      end
    join
    if (!stallSeen) begin
      otherErrs++;
      $display("reqReady never fell while rspReady was held low");
    end
    readyMode <= 3;
    for (int i = 0; i < RAND_OPS; i++) randomOp();
    reqValid <= 1'b0;

    // Drain, then watch a little longer for stray responses
    while (rspCount < issuedCount) @(posedge clk);
    repeat (10) @(posedge clk);
    $display("Done: %0d operations, %0d responses, %0d value errors, %0d other errors",
             issuedCount, rspCount, valueErrs, otherErrs);
    if (valueErrs == 0 && otherErrs == 0 && rspCount == issuedCount) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
